// File: Makefile
# Verilator flow for the I/O and work-RAM bus
TOP             ?= tb_gb_io_top
FILELIST        ?= gb_io_top.f
LOG             ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert
LINT_FLAGS      ?= --lint-only --timing -Wall

PASS_TEXT := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The log decides pass or fail, not the exit status of the binary
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: gb_bus_fabric.sv
`timescale 1ns/100ps
`include "gb_consts.svh"

module gb_bus_fabric (
    input  logic              clk,
    input  logic              reset,
    input  gb_pkg::apb_req_t  apb_req,
    output gb_pkg::apb_rsp_t  apb_rsp,
    output gb_pkg::gb_bus_t   bus,
    input  logic [7:0]        wram_rdata,
    input  logic [7:0]        timer_rdata,
    input  logic [7:0]        joypad_rdata,
    input  logic [7:0]        irq_rdata
);

    logic            in_wram;   // C000..DFFF
    logic            in_echo;   // E000..FDFF
    logic            in_timer;  // FF04..FF07
    logic            access;    // Access phase of APB
    logic            wram_read;
    logic            wait_done; // First WRAM read cycle already spent
    logic            ready;
    gb_pkg::region_e region;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    assign in_wram  = (apb_req.paddr >= `GB_WRAM_START) && (apb_req.paddr <= `GB_WRAM_END);
    assign in_echo  = (apb_req.paddr >= `GB_ECHO_START) && (apb_req.paddr <= `GB_ECHO_END);
    assign in_timer = (apb_req.paddr >= `GB_ADDR_DIV) && (apb_req.paddr <= `GB_ADDR_TAC);

    always_comb begin
        region = gb_pkg::region_unmapped; // Anything not listed below
        if (in_wram || in_echo) begin
            region = gb_pkg::region_wram; // Mirror lands on the same RAM
        end else if (apb_req.paddr == `GB_ADDR_JOYPAD) begin
            region = gb_pkg::region_joypad;
        end else if (in_timer) begin
            region = gb_pkg::region_timer;
        end else if (apb_req.paddr == `GB_ADDR_IF) begin
            region = gb_pkg::region_irq_flag;
        end else if (apb_req.paddr == `GB_ADDR_IE) begin
            region = gb_pkg::region_irq_enable;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Wait state and handshake
    ////////////////////////////////////////////////////////////////////////////

    assign access    = apb_req.psel & apb_req.penable;
    assign wram_read = access & ~apb_req.pwrite & (region == gb_pkg::region_wram);

    // Set after the first WRAM read cycle, drops once the transfer completes
    always_ff @(posedge clk) begin
        if (reset) begin
            wait_done <= 1'b0;
        end else begin
            wait_done <= wram_read & ~wait_done;
        end
    end

    // RAM data lands one clock after the strobe, so hold off one cycle
    assign ready = access & (~wram_read | wait_done);

    // Internal access seen by every peripheral
    assign bus.addr   = apb_req.paddr;
    assign bus.wdata  = apb_req.pwdata;
    assign bus.rd     = access & ~apb_req.pwrite;
    assign bus.wr     = access & apb_req.pwrite & ready; // Lands exactly once
    assign bus.region = region;

    assign apb_rsp.pready = ready; // Low outside an access

    ////////////////////////////////////////////////////////////////////////////
    // Read data steering
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (region)
            gb_pkg::region_wram:       apb_rsp.prdata = wram_rdata;
            gb_pkg::region_joypad:     apb_rsp.prdata = joypad_rdata;
            gb_pkg::region_timer:      apb_rsp.prdata = timer_rdata;
            gb_pkg::region_irq_flag,
            gb_pkg::region_irq_enable: apb_rsp.prdata = irq_rdata; // IF and IE share a port
            default:                   apb_rsp.prdata = 8'h00;     // Unmapped
        endcase
    end

endmodule

// File: gb_consts.svh
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// I/O register addresses
////////////////////////////////////////////////////////////////////////////

`define GB_ADDR_JOYPAD    16'hFF00 // P1 select and key lines
`define GB_ADDR_DIV       16'hFF04 // Upper byte of divider
`define GB_ADDR_TIMA      16'hFF05 // Timer counter
`define GB_ADDR_TMA       16'hFF06 // Timer reload value
`define GB_ADDR_TAC       16'hFF07 // Enable plus clock select
`define GB_ADDR_IF        16'hFF0F // Interrupt flags
`define GB_ADDR_IE        16'hFFFF // Interrupt enables

////////////////////////////////////////////////////////////////////////////
// Memory regions
////////////////////////////////////////////////////////////////////////////

// Work RAM proper
`define GB_WRAM_START     16'hC000
`define GB_WRAM_END       16'hDFFF

// Mirror of work RAM, stops short of OAM
`define GB_ECHO_START     16'hE000
`define GB_ECHO_END       16'hFDFF

`define GB_WRAM_AW        13 // 8 KB of bytes

// Divider bit per TAC clock select value 0..3
`define GB_TIMER_TAP0     9 // 4096 Hz on the real part
`define GB_TIMER_TAP1     3 // Fastest, falls every 16 clocks
`define GB_TIMER_TAP2     5
`define GB_TIMER_TAP3     7

`endif

// File: gb_io_top.f
+incdir+.
gb_pkg.sv
gb_bus_fabric.sv
gb_wram.sv
gb_timer.sv
gb_irq_ctrl.sv
gb_joypad.sv
gb_io_top.sv
gb_io_top_properties.sv
tb_gb_io_top.sv

// File: gb_io_top.sv
`timescale 1ns/100ps

module gb_io_top (
    input  logic             clk,
    input  logic             reset,
    input  gb_pkg::apb_req_t apb_req,
    output gb_pkg::apb_rsp_t apb_rsp,
    input  logic [7:0]       keys,
    input  logic             int_vblank,
    input  logic             int_lcd_stat,
    output logic             irq_pending,
    output gb_pkg::irq_reg_u irq_active
);

    gb_pkg::gb_bus_t bus;          // Shared access to all peripherals
    logic [7:0]      wram_rdata;
    logic [7:0]      timer_rdata;
    logic [7:0]      joypad_rdata;
    logic [7:0]      irq_rdata;
    logic            timer_req;    // Overflow pulse
    logic            joypad_req;   // Key press pulse

    ////////////////////////////////////////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////////////////////////////////////////

    gb_bus_fabric i_gb_bus_fabric (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .bus          (bus),
        .wram_rdata   (wram_rdata),
        .timer_rdata  (timer_rdata),
        .joypad_rdata (joypad_rdata),
        .irq_rdata    (irq_rdata)
    );

    gb_wram i_gb_wram (
        .clk   (clk),
        .bus   (bus),
        .rdata (wram_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////////////////////////////////////////

    gb_timer i_gb_timer (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .rdata     (timer_rdata),
        .timer_req (timer_req)
    );

    gb_joypad i_gb_joypad (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .keys       (keys),
        .rdata      (joypad_rdata),
        .joypad_req (joypad_req)
    );

    gb_irq_ctrl i_gb_irq_ctrl (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .timer_req    (timer_req),
        .joypad_req   (joypad_req),
        .int_vblank   (int_vblank),   // From outside
        .int_lcd_stat (int_lcd_stat),
        .rdata        (irq_rdata),
        .irq_pending  (irq_pending),
        .irq_active   (irq_active)
    );

endmodule

// File: gb_io_top_properties.sv
`timescale 1ns/100ps

module gb_io_top_properties (
    input  logic             clk,
    input  logic             reset,
    input  gb_pkg::apb_req_t apb_req,
    input  gb_pkg::apb_rsp_t apb_rsp,
    input  gb_pkg::gb_bus_t  bus,
    input  logic             irq_pending
);

    logic setup;          // APB setup phase
    logic setup_wram_rd;  // Setup of a work-RAM read
    logic setup_fast;     // Setup of anything that needs no wait state
    logic joypad_rd;      // P1 read on the internal bus

    assign setup         = apb_req.psel & ~apb_req.penable;
    assign setup_wram_rd = setup & ~apb_req.pwrite & (bus.region == gb_pkg::region_wram);
    assign setup_fast    = setup & (bus.region != gb_pkg::region_wram);
    assign joypad_rd     = bus.rd & (bus.region == gb_pkg::region_joypad);

    ////////////////////////////////////////////////////////////////////////////
    // Reset state and bus timing
    ////////////////////////////////////////////////////////////////////////////

    pending_after_reset: assert property (@(posedge clk) reset |=> !irq_pending)
        else $error("irq_pending high in the cycle after reset");

    // First access cycle of a RAM read is the wait state
    wram_wait: assert property (@(posedge clk) disable iff (reset)
        $past(setup_wram_rd) |-> !apb_rsp.pready)
        else $error("WRAM read completed without its wait state");

    wram_done: assert property (@(posedge clk) disable iff (reset)
        $past(setup_wram_rd, 2) |-> apb_rsp.pready)
        else $error("WRAM read not ready in its second access cycle");

    fast_done: assert property (@(posedge clk) disable iff (reset)
        $past(setup_fast) |-> apb_rsp.pready)
        else $error("Register access not ready in its first access cycle");

    // P1 value as the master sees it through the read mux
    joypad_top_bits: assert property (@(posedge clk) disable iff (reset)
        joypad_rd |-> (apb_rsp.prdata[7:6] == 2'b11))
        else $error("Joypad read data bits 7:6 not high");

endmodule

bind gb_io_top gb_io_top_properties i_gb_io_top_properties (
    .clk          (clk),
    .reset        (reset),
    .apb_req      (apb_req),
    .apb_rsp      (apb_rsp),
    .bus          (bus),
    .irq_pending  (irq_pending)
);

// File: gb_irq_ctrl.sv
`timescale 1ns/100ps

module gb_irq_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  gb_pkg::gb_bus_t  bus,
    input  logic             timer_req,
    input  logic             joypad_req,
    input  logic             int_vblank,
    input  logic             int_lcd_stat,
    output logic [7:0]       rdata,
    output logic             irq_pending,
    output gb_pkg::irq_reg_u irq_active
);

    gb_pkg::irq_reg_u if_q;    // IF
    gb_pkg::irq_reg_u ie_q;    // IE
    gb_pkg::irq_reg_u if_next;
    logic             wr_if;
    logic             wr_ie;

    assign wr_if = bus.wr && (bus.region == gb_pkg::region_irq_flag);
    assign wr_ie = bus.wr && (bus.region == gb_pkg::region_irq_enable);

    ////////////////////////////////////////////////////////////////////////////
    // Flag update
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if_next.raw = wr_if ? bus.wdata : if_q.raw; // Bus write replaces
        // Requests in the same cycle still win
        if_next.bits.vblank   = if_next.bits.vblank   | int_vblank;
        if_next.bits.lcd_stat = if_next.bits.lcd_stat | int_lcd_stat;
        if_next.bits.timer    = if_next.bits.timer    | timer_req;
        if_next.bits.joypad   = if_next.bits.joypad   | joypad_req;
        if_next.bits.serial   = 1'b0; // No serial port here
        if_next.bits.unused   = 3'b000;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            if_q.raw <= 8'h00;
            ie_q.raw <= 8'h00;
        end else begin
            if_q <= if_next;
            if (wr_ie) begin
                ie_q.raw <= {3'b000, bus.wdata[4:0]}; // Only five sources
            end
        end
    end

    // Masked flags, straight from the registers
    assign irq_active.raw = if_q.raw & ie_q.raw;
    assign irq_pending    = |irq_active.raw;

    // Upper three bits always read back high
    assign rdata = (bus.region == gb_pkg::region_irq_enable) ? {3'b111, ie_q.raw[4:0]}
                                                             : {3'b111, if_q.raw[4:0]};

endmodule

// File: gb_joypad.sv
`timescale 1ns/100ps

module gb_joypad (
    input  logic            clk,
    input  logic            reset,
    input  gb_pkg::gb_bus_t bus,
    input  logic [7:0]      keys,     // High while pressed
    output logic [7:0]      rdata,
    output logic            joypad_req
);

    logic [1:0] sel;       // P1 bits 5:4, active low
    logic [3:0] lines;     // Low for a pressed key in a selected group
    logic [3:0] lines_q;

    // Bit 5 picks buttons, bit 4 picks directions
    assign lines = ~(((~sel[1]) ? keys[7:4] : 4'h0) |
                     ((~sel[0]) ? keys[3:0] : 4'h0));

    assign rdata = {2'b11, sel, lines};

    always_ff @(posedge clk) begin
        if (reset) begin
            sel        <= 2'b11; // Nothing selected
            lines_q    <= 4'hF;
            joypad_req <= 1'b0;
        end else begin
            if (bus.wr && (bus.region == gb_pkg::region_joypad)) begin
                sel <= bus.wdata[5:4];
            end
            lines_q    <= lines;
            joypad_req <= |(lines_q & ~lines); // Any line going high to low
        end
    end

endmodule

// File: gb_pkg.sv
package gb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // APB side
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [7:0]  pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [7:0] prdata;
        logic       pready; // No error response, every access succeeds
    } apb_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // Internal bus
    ////////////////////////////////////////////////////////////////////////////

    // Decoded target of one address
    typedef enum logic [2:0] {
        region_wram,       // Includes the echo mirror
        region_joypad,
        region_timer,      // DIV, TIMA, TMA, TAC
        region_irq_flag,
        region_irq_enable,
        region_unmapped    // Reads as 0x00
    } region_e;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;     // High through every read access cycle
        logic        wr;     // Completing cycle only
        region_e     region;
    } gb_bus_t;

    // IF and IE layout, raw for the bus or by source
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] unused; // Read back as 1
            logic       joypad;
            logic       serial;
            logic       timer;
            logic       lcd_stat;
            logic       vblank;
        } bits;
    } irq_reg_u;

endpackage

// File: gb_timer.sv
`timescale 1ns/100ps
`include "gb_consts.svh"

module gb_timer (
    input  logic            clk,
    input  logic            reset,
    input  gb_pkg::gb_bus_t bus,
    output logic [7:0]      rdata,
    output logic            timer_req
);

    logic [15:0] div_cnt;  // Free running, DIV is the top byte
    logic [7:0]  tima;
    logic [7:0]  tma;
    logic [2:0]  tac;      // Enable plus clock select
    logic        tap_bit;  // Selected divider bit
    logic        tap_q;
    logic        tap_fall;
    logic        hit;
    logic        wr_div;
    logic        wr_tima;
    logic        wr_tma;
    logic        wr_tac;

    assign hit     = bus.wr && (bus.region == gb_pkg::region_timer);
    assign wr_div  = hit && (bus.addr == `GB_ADDR_DIV);
    assign wr_tima = hit && (bus.addr == `GB_ADDR_TIMA);
    assign wr_tma  = hit && (bus.addr == `GB_ADDR_TMA);
    assign wr_tac  = hit && (bus.addr == `GB_ADDR_TAC);

    ////////////////////////////////////////////////////////////////////////////
    // Tap select and edge detect
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (tac[1:0])
            2'b00:   tap_bit = div_cnt[`GB_TIMER_TAP0];
            2'b01:   tap_bit = div_cnt[`GB_TIMER_TAP1];
            2'b10:   tap_bit = div_cnt[`GB_TIMER_TAP2];
            default: tap_bit = div_cnt[`GB_TIMER_TAP3];
        endcase
    end

    assign tap_fall = tac[2] & tap_q & ~tap_bit; // Only counts when enabled

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= 16'h0000;
            tap_q     <= 1'b0;
            tima      <= 8'h00;
            tma       <= 8'h00;
            tac       <= 3'b000;
            timer_req <= 1'b0;
        end else begin
            div_cnt   <= wr_div ? 16'h0000 : div_cnt + 16'd1; // Any DIV write clears
            tap_q     <= tap_bit;
            timer_req <= 1'b0;
            if (wr_tima) begin
                tima <= bus.wdata; // Bus write beats the increment
            end else if (tap_fall) begin
                if (tima == 8'hFF) begin
                    tima      <= tma; // Reload and request together
                    timer_req <= 1'b1;
                end else begin
                    tima <= tima + 8'd1;
                end
            end
            if (wr_tma) tma <= bus.wdata;
            if (wr_tac) tac <= bus.wdata[2:0];
        end
    end

    // Register read back
    always_comb begin
        case (bus.addr)
            `GB_ADDR_DIV:  rdata = div_cnt[15:8];
            `GB_ADDR_TIMA: rdata = tima;
            `GB_ADDR_TMA:  rdata = tma;
            `GB_ADDR_TAC:  rdata = {5'b11111, tac}; // Unused bits read high
            default:       rdata = 8'hFF;
        endcase
    end

endmodule

// File: gb_wram.sv
`timescale 1ns/100ps
`include "gb_consts.svh"

module gb_wram (
    input  logic            clk,
    input  gb_pkg::gb_bus_t bus,
    output logic [7:0]      rdata
);

    localparam int DEPTH = 1 << `GB_WRAM_AW; // 8192 bytes

    logic [7:0]              mem [0:DEPTH-1];
    logic [`GB_WRAM_AW-1:0]  index;
    logic                    hit;

    // Low 13 bits fold E000.. onto C000.., no subtract needed
    assign index = bus.addr[`GB_WRAM_AW-1:0];
    assign hit   = (bus.region == gb_pkg::region_wram);

    // Single port, write first in code order
    always_ff @(posedge clk) begin
        if (bus.wr && hit) begin
            mem[index] <= bus.wdata;
        end
        if (bus.rd && hit) begin
            rdata <= mem[index]; // Valid the cycle after the strobe
        end
    end

endmodule

// File: tb_gb_io_top.sv
`timescale 1ns/100ps
`include "gb_consts.svh"

module tb_gb_io_top;

    localparam int WAIT_LIMIT     = 16;  // Cycles per wait before giving up
    localparam int POLL_LIMIT     = 40;  // IF reads while waiting for overflow
    localparam int DIV_POLL_LIMIT = 120; // DIV reads until the upper byte moves

    logic             clk;
    logic             reset;
    gb_pkg::apb_req_t apb_req;
    gb_pkg::apb_rsp_t apb_rsp;
    logic [7:0]       keys;
    logic             int_vblank;
    logic             int_lcd_stat;
    logic             irq_pending;
    gb_pkg::irq_reg_u irq_active;

    int               errors;
    int               tests;
    logic [31:0]      lcg_state;

    gb_io_top i_gb_io_top (
        .clk          (clk),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .keys         (keys),
        .int_vblank   (int_vblank),
        .int_lcd_stat (int_lcd_stat),
        .irq_pending  (irq_pending),
        .irq_active   (irq_active)
    );

    always #10 clk = ~clk; // 20 ns period

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////////////////////

    // Samples pready 5 ns into the low phase
    task automatic wait_ready(input logic [15:0] addr);
        int cycles;
        cycles = 0;
        #5;
        while (!apb_rsp.pready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #5;
            cycles++;
        end
        if (!apb_rsp.pready) begin
            $display("Timeout: no pready at address %h within %0d cycles", addr, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic apb_start(input logic [15:0] addr, input logic wr, input logic [7:0] data);
        @(negedge clk);
        apb_req.psel    = 1'b1; // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1; // Access phase
        wait_ready(addr);
    endtask

    task automatic apb_idle();
        @(negedge clk); // Transfer done on the edge before
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [15:0] addr, input logic [7:0] data);
        apb_start(addr, 1'b1, data);
        apb_idle();
    endtask

    task automatic apb_read(input logic [15:0] addr, output logic [7:0] data);
        apb_start(addr, 1'b0, 8'h00);
        data = apb_rsp.prdata;
        apb_idle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks and reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic compare_irq(input string name, input gb_pkg::irq_reg_u got,
                               input gb_pkg::irq_reg_u want);
        if (got.raw !== want.raw) begin
            $display("Mismatch %s: got %h, expected %h", name, got.raw, want.raw);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic check_flag(input logic cond, input string what);
        if (!cond) begin
            $display("Check failed: %s", what);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic wram_round_trip();
        int          start;
        logic [15:0] addr;
        logic [7:0]  got;
        logic [31:0] r;
        start = errors;
        for (int i = 0; i < 16; i++) begin
            r    = next_random();
            addr = {3'b110, r[12:0]}; // Somewhere in C000..DFFF
            apb_write(addr, r[23:16]);
            apb_read(addr, got);
            compare_byte($sformatf("wram %h", addr), got, r[23:16]);
        end
        r = next_random();
        apb_write({4'hE, r[11:0]}, r[27:20]); // Echo side
        apb_read({4'hC, r[11:0]}, got);
        compare_byte("wram via echo", got, r[27:20]);
        finish_test("wram", start);
    endtask

    task automatic unmapped_and_ie();
        int          start;
        logic [15:0] holes [4];
        logic [7:0]  got;
        logic [31:0] r;
        start    = errors;
        holes[0] = 16'h8000; // VRAM
        holes[1] = 16'hFF01; // Serial data
        holes[2] = 16'hFF80; // HRAM
        holes[3] = 16'hFE00; // OAM
        foreach (holes[i]) begin
            apb_read(holes[i], got);
            compare_byte($sformatf("unmapped %h", holes[i]), got, 8'h00);
        end
        r = next_random();
        apb_write(`GB_ADDR_IE, r[7:0]);
        apb_read(`GB_ADDR_IE, got);
        compare_byte("IE", got, {3'b111, r[4:0]});
        apb_write(`GB_ADDR_IE, 8'h00);
        finish_test("unmapped and IE", start);
    endtask

    task automatic timer_overflow();
        int         start;
        int         polls;
        logic [7:0] flags;
        logic [7:0] got;
        start = errors;
        apb_write(`GB_ADDR_TMA, 8'hF0);
        apb_write(`GB_ADDR_TIMA, 8'hFE);
        apb_write(`GB_ADDR_TAC, 8'h05); // Enable with divider bit 3
        polls = 0;
        flags = 8'h00;
        while (!flags[2] && polls < POLL_LIMIT) begin
            apb_read(`GB_ADDR_IF, flags);
            polls++;
        end
        check_flag(flags[2], "timer bit in IF never set after TIMA overflow");
        apb_read(`GB_ADDR_TIMA, got);
        check_flag(got >= 8'hF0, "TIMA below the TMA reload value after overflow");
        polls = 0;
        got   = 8'h00;
        while (got == 8'h00 && polls < DIV_POLL_LIMIT) begin
            apb_read(`GB_ADDR_DIV, got); // Wait for the upper byte to move off zero
            polls++;
        end
        check_flag(got != 8'h00, "DIV never advanced past zero");
        apb_write(`GB_ADDR_DIV, 8'h5A); // Any value clears
        apb_read(`GB_ADDR_DIV, got);
        compare_byte("DIV", got, 8'h00);
        finish_test("timer", start);
    endtask

    task automatic timer_interrupt();
        int               start;
        int               cycles;
        gb_pkg::irq_reg_u want;
        start = errors;
        apb_write(`GB_ADDR_TAC, 8'h00); // Timer stops but IF keeps its bit
        apb_write(`GB_ADDR_IE, 8'h04);
        cycles = 0;
        while (!irq_pending && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        check_flag(irq_pending, "irq_pending did not rise with timer flag and enable set");
        want.raw       = 8'h00;
        want.bits.timer = 1'b1;
        compare_irq("irq_active", irq_active, want);
        apb_write(`GB_ADDR_IF, 8'h00);
        check_flag(!irq_pending, "irq_pending still high after IF cleared");
        want.raw = 8'h00;
        compare_irq("irq_active", irq_active, want);
        finish_test("timer interrupt", start);
    endtask

    task automatic external_interrupts();
        int               start;
        logic [7:0]       got;
        gb_pkg::irq_reg_u want;
        start = errors;
        @(negedge clk);
        int_vblank   = 1'b1;
        @(negedge clk);
        int_vblank   = 1'b0;
        int_lcd_stat = 1'b1;
        @(negedge clk);
        int_lcd_stat = 1'b0;
        apb_read(`GB_ADDR_IF, got);
        compare_byte("IF", got, 8'hE3); // vblank and lcd_stat
        want.raw = 8'h00;               // IE holds only the timer bit
        compare_irq("irq_active", irq_active, want);
        apb_write(`GB_ADDR_IF, 8'h00);
        finish_test("external interrupts", start);
    endtask

    task automatic joypad_select();
        int         start;
        logic [7:0] got;
        start = errors;
        apb_write(`GB_ADDR_JOYPAD, 8'h20); // Directions selected
        @(negedge clk);
        keys = 8'h04;
        apb_read(`GB_ADDR_JOYPAD, got);
        compare_byte("P1", got, 8'hEB);
        apb_read(`GB_ADDR_IF, got);
        compare_byte("IF", got, 8'hF0);
        apb_write(`GB_ADDR_JOYPAD, 8'h30); // Nothing selected
        apb_read(`GB_ADDR_JOYPAD, got);
        compare_byte("P1 low nibble", {4'h0, got[3:0]}, 8'h0F);
        keys = 8'h00;
        finish_test("joypad", start);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        apb_req      = '0;
        keys         = 8'h00;
        int_vblank   = 1'b0;
        int_lcd_stat = 1'b0;
        errors       = 0;
        tests        = 0;
        lcg_state    = 32'd62631;
        repeat (2) @(negedge clk); // Two rising edges in reset
        reset = 1'b0;
        wram_round_trip();
        unmapped_and_ie();
        timer_overflow();
        timer_interrupt();
        external_interrupts();
        joypad_select();
        $display("Ran %0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
